//--- Makefile
TOP = tb_axi_tlul_mem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -f filelist.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
+incdir+src
src/tlul_pkg.sv
src/axi_tlul_wr_shim.sv
src/axi_tlul_rd_shim.sv
src/tlul_host_arb.sv
src/tlul_mem.sv
src/axi_tlul_mem_top.sv
tb/tb_axi_tlul_mem.sv

//--- src/axi_tlul_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_tlul_mem_top
    import tlul_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // AXI4-Lite slave port
    input  addr_t     awaddr_i,
    input  logic      awvalid_i,
    output logic      awready_o,
    input  data_t     wdata_i,
    input  strb_t     wstrb_i,
    input  logic      wvalid_i,
    output logic      wready_o,
    output axi_resp_t bresp_o,
    output logic      bvalid_o,
    input  logic      bready_i,
    input  addr_t     araddr_i,
    input  logic      arvalid_i,
    output logic      arready_o,
    output data_t     rdata_o,
    output axi_resp_t rresp_o,
    output logic      rvalid_o,
    input  logic      rready_i
);

    // --------------------------------------------------
    // Write bridge to arbiter host 0
    logic       wr_a_valid, wr_a_ready, wr_d_valid, wr_d_ready, wr_d_error;
    tl_opcode_t wr_a_opcode;
    addr_t      wr_a_address;
    strb_t      wr_a_mask;
    data_t      wr_a_data;

    // Read bridge to arbiter host 1
    logic       rd_a_valid, rd_a_ready, rd_d_valid, rd_d_ready, rd_d_error;
    addr_t      rd_a_address;
    data_t      rd_d_data;

    // Arbiter to memory
    logic       dev_a_valid, dev_a_ready, dev_d_valid, dev_d_ready, dev_d_error;
    tl_opcode_t dev_a_opcode;
    source_t    dev_a_source, dev_d_source;
    addr_t      dev_a_address;
    strb_t      dev_a_mask;
    data_t      dev_a_data, dev_d_data;

    axi_tlul_wr_shim wr_shim_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .awaddr_i       (awaddr_i),
        .awvalid_i      (awvalid_i),
        .awready_o      (awready_o),
        .wdata_i        (wdata_i),
        .wstrb_i        (wstrb_i),
        .wvalid_i       (wvalid_i),
        .wready_o       (wready_o),
        .bresp_o        (bresp_o),
        .bvalid_o       (bvalid_o),
        .bready_i       (bready_i),
        .tl_a_valid_o   (wr_a_valid),
        .tl_a_ready_i   (wr_a_ready),
        .tl_a_opcode_o  (wr_a_opcode),
        .tl_a_address_o (wr_a_address),
        .tl_a_mask_o    (wr_a_mask),
        .tl_a_data_o    (wr_a_data),
        .tl_d_valid_i   (wr_d_valid),
        .tl_d_ready_o   (wr_d_ready),
        .tl_d_error_i   (wr_d_error)
    );

    axi_tlul_rd_shim rd_shim_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .araddr_i       (araddr_i),
        .arvalid_i      (arvalid_i),
        .arready_o      (arready_o),
        .rdata_o        (rdata_o),
        .rresp_o        (rresp_o),
        .rvalid_o       (rvalid_o),
        .rready_i       (rready_i),
        .tl_a_valid_o   (rd_a_valid),
        .tl_a_ready_i   (rd_a_ready),
        .tl_a_address_o (rd_a_address),
        .tl_d_valid_i   (rd_d_valid),
        .tl_d_ready_o   (rd_d_ready),
        .tl_d_data_i    (rd_d_data),
        .tl_d_error_i   (rd_d_error)
    );

    tlul_host_arb arb_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .h0_a_valid_i    (wr_a_valid),
        .h0_a_ready_o    (wr_a_ready),
        .h0_a_opcode_i   (wr_a_opcode),
        .h0_a_address_i  (wr_a_address),
        .h0_a_mask_i     (wr_a_mask),
        .h0_a_data_i     (wr_a_data),
        .h0_d_valid_o    (wr_d_valid),
        .h0_d_ready_i    (wr_d_ready),
        .h0_d_error_o    (wr_d_error),
        .h1_a_valid_i    (rd_a_valid),
        .h1_a_ready_o    (rd_a_ready),
        .h1_a_address_i  (rd_a_address),
        .h1_d_valid_o    (rd_d_valid),
        .h1_d_ready_i    (rd_d_ready),
        .h1_d_data_o     (rd_d_data),
        .h1_d_error_o    (rd_d_error),
        .dev_a_valid_o   (dev_a_valid),
        .dev_a_ready_i   (dev_a_ready),
        .dev_a_opcode_o  (dev_a_opcode),
        .dev_a_source_o  (dev_a_source),
        .dev_a_address_o (dev_a_address),
        .dev_a_mask_o    (dev_a_mask),
        .dev_a_data_o    (dev_a_data),
        .dev_d_valid_i   (dev_d_valid),
        .dev_d_ready_o   (dev_d_ready),
        .dev_d_source_i  (dev_d_source),
        .dev_d_data_i    (dev_d_data),
        .dev_d_error_i   (dev_d_error)
    );

    // D opcode left open, the source tag already tells Put from Get
    tlul_mem mem_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .tl_a_valid_i   (dev_a_valid),
        .tl_a_ready_o   (dev_a_ready),
        .tl_a_opcode_i  (dev_a_opcode),
        .tl_a_source_i  (dev_a_source),
        .tl_a_address_i (dev_a_address),
        .tl_a_mask_i    (dev_a_mask),
        .tl_a_data_i    (dev_a_data),
        .tl_d_valid_o   (dev_d_valid),
        .tl_d_ready_i   (dev_d_ready),
        .tl_d_opcode_o  (),
        .tl_d_source_o  (dev_d_source),
        .tl_d_data_o    (dev_d_data),
        .tl_d_error_o   (dev_d_error)
    );

endmodule

`default_nettype wire

//--- src/axi_tlul_rd_shim.sv
`timescale 1ns/1ps
`default_nettype none

module axi_tlul_rd_shim
    import tlul_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // AXI4-Lite read address
    input  addr_t     araddr_i,
    input  logic      arvalid_i,
    output logic      arready_o,
    // AXI4-Lite read data
    output data_t     rdata_o,
    output axi_resp_t rresp_o,
    output logic      rvalid_o,
    input  logic      rready_i,
    // TL-UL A channel, opcode and mask added by the arbiter
    output logic      tl_a_valid_o,
    input  logic      tl_a_ready_i,
    output addr_t     tl_a_address_o,
    // TL-UL D channel
    input  logic      tl_d_valid_i,
    output logic      tl_d_ready_o,
    input  data_t     tl_d_data_i,
    input  logic      tl_d_error_i
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_REQ,
        RD_WAIT_DATA,
        RD_RESP
    } rd_state_e;

    rd_state_e state_q, state_d;
    logic      ar_hs, d_hs;
    addr_t     addr_q;
    data_t     rdata_q;
    axi_resp_t rresp_q;

    assign arready_o = (state_q == RD_IDLE);
    assign ar_hs     = arvalid_i && arready_o;
    assign d_hs      = tl_d_valid_i && tl_d_ready_o;

    // Address and R payload capture
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            addr_q <= araddr_i;
        end
        // Error data forced to zero
        if (d_hs) begin
            rdata_q <= tl_d_error_i ? '0 : tl_d_data_i;
            rresp_q <= tl_d_error_i ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // --------------------------------------------------
    // Get sequencing
    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE:      if (arvalid_i) state_d = RD_REQ;
            RD_REQ:       if (tl_a_ready_i) state_d = RD_WAIT_DATA;
            RD_WAIT_DATA: if (tl_d_valid_i) state_d = RD_RESP;
            RD_RESP:      if (rready_i) state_d = RD_IDLE;
            default:      state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= RD_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign tl_a_valid_o   = (state_q == RD_REQ);
    assign tl_a_address_o = addr_q;
    assign tl_d_ready_o   = (state_q == RD_WAIT_DATA);

    // R held stable under rready back-pressure
    assign rvalid_o = (state_q == RD_RESP);
    assign rdata_o  = rdata_q;
    assign rresp_o  = rresp_q;

endmodule

`default_nettype wire

//--- src/axi_tlul_wr_shim.sv
`timescale 1ns/1ps
`default_nettype none

module axi_tlul_wr_shim
    import tlul_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // AXI4-Lite write address
    input  addr_t      awaddr_i,
    input  logic       awvalid_i,
    output logic       awready_o,
    // AXI4-Lite write data
    input  data_t      wdata_i,
    input  strb_t      wstrb_i,
    input  logic       wvalid_i,
    output logic       wready_o,
    // AXI4-Lite write response
    output axi_resp_t  bresp_o,
    output logic       bvalid_o,
    input  logic       bready_i,
    // TL-UL A channel, host side
    output logic       tl_a_valid_o,
    input  logic       tl_a_ready_i,
    output tl_opcode_t tl_a_opcode_o,
    output addr_t      tl_a_address_o,
    output strb_t      tl_a_mask_o,
    output data_t      tl_a_data_o,
    // TL-UL D channel, host side
    input  logic       tl_d_valid_i,
    output logic       tl_d_ready_o,
    input  logic       tl_d_error_i
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_REQ,
        WR_WAIT_ACK,
        WR_RESP
    } wr_state_e;

    wr_state_e state_q, state_d;
    logic      aw_held_q, w_held_q;
    logic      aw_hs, w_hs, b_hs, d_hs;
    addr_t     addr_q;
    data_t     data_q;
    strb_t     strb_q;
    axi_resp_t bresp_q;

    // --------------------------------------------------
    // AXI side handshakes
    assign awready_o = !aw_held_q;
    assign wready_o  = !w_held_q;
    assign aw_hs     = awvalid_i && awready_o;
    assign w_hs      = wvalid_i && wready_o;
    assign b_hs      = bvalid_o && bready_i;
    assign d_hs      = tl_d_valid_i && tl_d_ready_o;

    // Flags stay set until B completes, blocks a second write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
        end else if (b_hs) begin
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
        end else begin
            aw_held_q <= aw_held_q || aw_hs;
            w_held_q  <= w_held_q || w_hs;
        end
    end

    // Address, data and response capture
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            addr_q <= awaddr_i;
        end
        if (w_hs) begin
            data_q <= wdata_i;
            strb_q <= wstrb_i;
        end
        if (d_hs) begin
            bresp_q <= tl_d_error_i ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // --------------------------------------------------
    // Put sequencing
    always_comb begin
        state_d = state_q;
        case (state_q)
            // Leave as soon as both halves are in, including this cycle
            WR_IDLE:     if ((aw_held_q || aw_hs) && (w_held_q || w_hs)) state_d = WR_REQ;
            WR_REQ:      if (tl_a_ready_i) state_d = WR_WAIT_ACK;
            WR_WAIT_ACK: if (tl_d_valid_i) state_d = WR_RESP;
            WR_RESP:     if (bready_i) state_d = WR_IDLE;
            default:     state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= WR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Full strobe maps to PutFullData
    assign tl_a_valid_o   = (state_q == WR_REQ);
    assign tl_a_opcode_o  = (&strb_q) ? PUT_FULL_DATA : PUT_PARTIAL_DATA;
    assign tl_a_address_o = addr_q;
    assign tl_a_mask_o    = strb_q;
    assign tl_a_data_o    = data_q;
    assign tl_d_ready_o   = (state_q == WR_WAIT_ACK);

    assign bvalid_o = (state_q == WR_RESP);
    assign bresp_o  = bresp_q;

endmodule

`default_nettype wire

//--- src/tlul_cfg.svh
`ifndef TLUL_CFG_SVH
`define TLUL_CFG_SVH

// Byte address width, AXI and TL-UL sides alike
`define TL_AW 32

// Data width, a multiple of 8
`define TL_DW 32

// Source tag width, one bit covers two hosts
`define TL_AIW 1

// Memory depth in words
`define MEM_WORDS 64

`endif

//--- src/tlul_host_arb.sv
`timescale 1ns/1ps
`default_nettype none

module tlul_host_arb
    import tlul_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // Host 0, write bridge
    input  logic       h0_a_valid_i,
    output logic       h0_a_ready_o,
    input  tl_opcode_t h0_a_opcode_i,
    input  addr_t      h0_a_address_i,
    input  strb_t      h0_a_mask_i,
    input  data_t      h0_a_data_i,
    output logic       h0_d_valid_o,
    input  logic       h0_d_ready_i,
    output logic       h0_d_error_o,
    // Host 1, read bridge
    input  logic       h1_a_valid_i,
    output logic       h1_a_ready_o,
    input  addr_t      h1_a_address_i,
    output logic       h1_d_valid_o,
    input  logic       h1_d_ready_i,
    output data_t      h1_d_data_o,
    output logic       h1_d_error_o,
    // Device side
    output logic       dev_a_valid_o,
    input  logic       dev_a_ready_i,
    output tl_opcode_t dev_a_opcode_o,
    output source_t    dev_a_source_o,
    output addr_t      dev_a_address_o,
    output strb_t      dev_a_mask_o,
    output data_t      dev_a_data_o,
    input  logic       dev_d_valid_i,
    output logic       dev_d_ready_o,
    input  source_t    dev_d_source_i,
    input  data_t      dev_d_data_i,
    input  logic       dev_d_error_i
);

    // Source tags, one per host
    localparam source_t SRC_WR = source_t'(0);
    localparam source_t SRC_RD = source_t'(1);

    source_t gnt;
    source_t prio_q;
    source_t lock_id_q;
    logic    lock_q;
    logic    a_hs;

    // --------------------------------------------------
    // Grant select, lock wins over priority
    always_comb begin
        if (lock_q) begin
            gnt = lock_id_q;
        end else if (h0_a_valid_i && h1_a_valid_i) begin
            gnt = prio_q;
        end else begin
            gnt = h1_a_valid_i ? SRC_RD : SRC_WR;
        end
    end

    assign a_hs = dev_a_valid_o && dev_a_ready_i;

    // Priority flips after each accepted beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio_q    <= SRC_WR;
            lock_q    <= 1'b0;
            lock_id_q <= SRC_WR;
        end else if (a_hs) begin
            prio_q <= (gnt == SRC_WR) ? SRC_RD : SRC_WR;
            lock_q <= 1'b0;
        end else if (dev_a_valid_o) begin
            // Stalled request keeps its grant
            lock_q    <= 1'b1;
            lock_id_q <= gnt;
        end
    end

    // A path mux, Get with full mask for the read host
    assign dev_a_valid_o   = (gnt == SRC_RD) ? h1_a_valid_i : h0_a_valid_i;
    assign dev_a_opcode_o  = (gnt == SRC_RD) ? GET : h0_a_opcode_i;
    assign dev_a_source_o  = gnt;
    assign dev_a_address_o = (gnt == SRC_RD) ? h1_a_address_i : h0_a_address_i;
    assign dev_a_mask_o    = (gnt == SRC_RD) ? '1 : h0_a_mask_i;
    assign dev_a_data_o    = (gnt == SRC_RD) ? '0 : h0_a_data_i;
    assign h0_a_ready_o    = dev_a_ready_i && (gnt == SRC_WR);
    assign h1_a_ready_o    = dev_a_ready_i && (gnt == SRC_RD);

    // --------------------------------------------------
    // D path, steered by source
    assign h0_d_valid_o  = dev_d_valid_i && (dev_d_source_i == SRC_WR);
    assign h1_d_valid_o  = dev_d_valid_i && (dev_d_source_i == SRC_RD);
    assign dev_d_ready_o = (dev_d_source_i == SRC_RD) ? h1_d_ready_i : h0_d_ready_i;
    assign h0_d_error_o  = dev_d_error_i;
    assign h1_d_error_o  = dev_d_error_i;
    assign h1_d_data_o   = dev_d_data_i;

endmodule

`default_nettype wire

//--- src/tlul_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlul_cfg.svh"

module tlul_mem
    import tlul_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // TL-UL A channel
    input  logic       tl_a_valid_i,
    output logic       tl_a_ready_o,
    input  tl_opcode_t tl_a_opcode_i,
    input  source_t    tl_a_source_i,
    input  addr_t      tl_a_address_i,
    input  strb_t      tl_a_mask_i,
    input  data_t      tl_a_data_i,
    // TL-UL D channel
    output logic       tl_d_valid_o,
    input  logic       tl_d_ready_i,
    output tl_opcode_t tl_d_opcode_o,
    output source_t    tl_d_source_o,
    output data_t      tl_d_data_o,
    output logic       tl_d_error_o
);

    localparam int IDX_W  = `TL_AW - 2;
    localparam int WORD_W = $clog2(`MEM_WORDS);

    data_t            mem_q [`MEM_WORDS];
    logic [IDX_W-1:0] a_idx;
    logic             a_in_range;
    logic             a_is_get;
    logic             a_hs;

    // Word index, byte offset dropped
    assign a_idx      = tl_a_address_i[`TL_AW-1:2];
    assign a_in_range = (a_idx < IDX_W'(`MEM_WORDS));
    assign a_is_get   = (tl_a_opcode_i == GET);

    // One response slot, refilled in the cycle it drains
    assign tl_a_ready_o = !tl_d_valid_o || tl_d_ready_i;
    assign a_hs         = tl_a_valid_i && tl_a_ready_o;

    // --------------------------------------------------
    // Storage, word i comes out of reset as i
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem_q[i] <= data_t'(i);
            end
        end else if (a_hs && a_in_range && !a_is_get) begin
            // Byte lanes under the mask only
            for (int b = 0; b < `TL_DW/8; b++) begin
                if (tl_a_mask_i[b]) begin
                    mem_q[a_idx[WORD_W-1:0]][8*b +: 8] <= tl_a_data_i[8*b +: 8];
                end
            end
        end
    end

    // --------------------------------------------------
    // Response valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tl_d_valid_o <= 1'b0;
        end else if (a_hs) begin
            tl_d_valid_o <= 1'b1;
        end else if (tl_d_ready_i) begin
            tl_d_valid_o <= 1'b0;
        end
    end

    // Response fields, only loaded on an accepted beat
    always_ff @(posedge clk) begin
        if (a_hs) begin
            tl_d_opcode_o <= a_is_get ? ACCESS_ACK_DATA : ACCESS_ACK;
            tl_d_source_o <= tl_a_source_i;
            tl_d_error_o  <= !a_in_range;
            tl_d_data_o   <= (a_is_get && a_in_range) ? mem_q[a_idx[WORD_W-1:0]] : '0;
        end
    end

endmodule

`default_nettype wire

//--- src/tlul_pkg.sv
`default_nettype none

`include "tlul_cfg.svh"

package tlul_pkg;

    // Byte address, bits 1:0 ignored by the memory
    typedef logic [`TL_AW-1:0]   addr_t;
    typedef logic [`TL_DW-1:0]   data_t;
    // One bit per data byte
    typedef logic [`TL_DW/8-1:0] strb_t;
    typedef logic [`TL_AIW-1:0]  source_t;

    typedef logic [2:0] tl_opcode_t;
    typedef logic [1:0] axi_resp_t;

    // --------------------------------------------------
    // TL-UL A channel opcodes
    localparam tl_opcode_t PUT_FULL_DATA    = 3'd0;
    localparam tl_opcode_t PUT_PARTIAL_DATA = 3'd1;
    localparam tl_opcode_t GET              = 3'd4;

    // TL-UL D channel opcodes
    localparam tl_opcode_t ACCESS_ACK      = 3'd0;
    localparam tl_opcode_t ACCESS_ACK_DATA = 3'd1;

    // --------------------------------------------------
    // AXI response codes
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- tb/tb_axi_tlul_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlul_cfg.svh"

module tb_axi_tlul_mem
    import tlul_pkg::*;
();

    localparam int TIMEOUT = 100;

    logic      clk;
    logic      rst_n;
    addr_t     awaddr;
    logic      awvalid;
    logic      awready;
    data_t     wdata;
    strb_t     wstrb;
    logic      wvalid;
    logic      wready;
    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;
    addr_t     araddr;
    logic      arvalid;
    logic      arready;
    data_t     rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;

    // Model of the memory contents
    data_t     ref_mem [`MEM_WORDS];
    string     test_name;
    integer    seed;

    axi_tlul_mem_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .awaddr_i  (awaddr),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bresp_o   (bresp),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .araddr_i  (araddr),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rdata_o   (rdata),
        .rresp_o   (rresp),
        .rvalid_o  (rvalid),
        .rready_i  (rready)
    );

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // Address rules and byte merging
    function automatic logic word_in_range(input addr_t addr);
        addr_t idx;
        idx = addr >> 2;
        return idx < addr_t'(`MEM_WORDS);
    endfunction

    function automatic int word_index(input addr_t addr);
        return int'(addr >> 2);
    endfunction

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input strb_t strb);
        data_t merged;
        merged = old_word;
        for (int b = 0; b < `TL_DW/8; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // --------------------------------------------------
    // Failure and compare tasks
    task automatic stop_on_failure(input string why);
        $display("Test FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_data(input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", test_name, exp, act);
            stop_on_failure("read data mismatch");
        end
    endtask

    task automatic check_resp(input axi_resp_t exp, input axi_resp_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", test_name, exp, act);
            stop_on_failure("response code mismatch");
        end
    endtask

    task automatic expect_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: %s expected %b, actual %b", test_name, what, exp, act);
            stop_on_failure("handshake signal at the wrong level");
        end
    endtask

    // --------------------------------------------------
    // AXI4-Lite channel drivers entered 1 ns after a rising edge
    task automatic send_aw(input addr_t addr);
        int waited;
        waited = 0;
        awaddr  = addr;
        awvalid = 1'b1;
        // Ready sampled mid-cycle with the handshake on the next edge
        @(negedge clk);
        while (!awready) begin
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_failure("awready never came high");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        awvalid = 1'b0;
    endtask

    task automatic send_w(input data_t data, input strb_t strb);
        int waited;
        waited = 0;
        wdata  = data;
        wstrb  = strb;
        wvalid = 1'b1;
        @(negedge clk);
        while (!wready) begin
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_failure("wready never came high");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        wvalid = 1'b0;
    endtask

    // Order 0 drives AW and W together
    // Order 1 sends AW first and order 2 sends W first
    task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
                             input int order, output axi_resp_t resp);
        int waited;
        waited = 0;
        case (order)
            1: begin
                send_aw(addr);
                send_w(data, strb);
            end
            2: begin
                send_w(data, strb);
                send_aw(addr);
            end
            default: begin
                fork
                    send_aw(addr);
                    send_w(data, strb);
                join
            end
        endcase
        bready = 1'b1;
        @(negedge clk);
        while (!bvalid) begin
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_failure("no write response within timeout");
            end
            @(negedge clk);
        end
        resp = bresp;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input addr_t addr, output data_t data, output axi_resp_t resp);
        int waited;
        waited  = 0;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) begin
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_failure("arready never came high");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        rready  = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!rvalid) begin
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_failure("no read response within timeout");
            end
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    // --------------------------------------------------
    // Accesses checked against the model
    task automatic write_and_check(input addr_t addr, input data_t data, input strb_t strb,
                                   input int order);
        axi_resp_t resp;
        axi_write(addr, data, strb, order, resp);
        if (word_in_range(addr)) begin
            check_resp(RESP_OKAY, resp);
            ref_mem[word_index(addr)] = merge_bytes(ref_mem[word_index(addr)], data, strb);
        end else begin
            check_resp(RESP_SLVERR, resp);
        end
    endtask

    task automatic read_and_check(input addr_t addr);
        data_t     data;
        axi_resp_t resp;
        axi_read(addr, data, resp);
        if (word_in_range(addr)) begin
            check_resp(RESP_OKAY, resp);
            check_data(ref_mem[word_index(addr)], data);
        end else begin
            // Error reads come back as zero
            check_resp(RESP_SLVERR, resp);
            check_data('0, data);
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    task automatic reset_contents();
        test_name = "reset_contents";
        // Idle bridges out of reset
        expect_flag("awready", 1'b1, awready);
        expect_flag("wready", 1'b1, wready);
        expect_flag("arready", 1'b1, arready);
        expect_flag("bvalid", 1'b0, bvalid);
        expect_flag("rvalid", 1'b0, rvalid);
        read_and_check(addr_t'(0));
        read_and_check(addr_t'(4));
        read_and_check(addr_t'(2*4));
        read_and_check(addr_t'(33*4));
        read_and_check(addr_t'(63*4));
    endtask

    task automatic full_write_readback();
        test_name = "full_write_readback";
        write_and_check(addr_t'(3*4), 32'hA5A5_0001, '1, 0);
        write_and_check(addr_t'(10*4), 32'h5A5A_0002, '1, 1);
        write_and_check(addr_t'(20*4), 32'hDEAD_BEEF, '1, 2);
        read_and_check(addr_t'(3*4));
        read_and_check(addr_t'(10*4));
        read_and_check(addr_t'(20*4));
    endtask

    task automatic partial_strobe();
        test_name = "partial_strobe";
        write_and_check(addr_t'(7*4), 32'h1122_3344, 4'b0101, 0);
        read_and_check(addr_t'(7*4));
        // Top byte only on a word written before
        write_and_check(addr_t'(10*4), 32'hFF00_0000, 4'b1000, 1);
        read_and_check(addr_t'(10*4));
    endtask

    task automatic out_of_range();
        test_name = "out_of_range";
        // Word 64 would alias word 0 if the range check leaked
        write_and_check(addr_t'(`MEM_WORDS*4), 32'h0BAD_0BAD, '1, 0);
        read_and_check(addr_t'(`MEM_WORDS*4));
        read_and_check(addr_t'(32'h8000_0000));
        read_and_check(addr_t'(0));
    endtask

    task automatic concurrent_backpressure();
        int    waited;
        logic  aw_done;
        logic  w_done;
        logic  ar_done;
        addr_t wr_addr;
        addr_t rd_addr;
        data_t wr_data;
        test_name = "concurrent_backpressure";
        wr_addr   = addr_t'(12*4);
        rd_addr   = addr_t'(30*4);
        wr_data   = 32'hCAFE_F00D;
        aw_done   = 1'b0;
        w_done    = 1'b0;
        ar_done   = 1'b0;
        waited    = 0;
        bready    = 1'b0;
        rready    = 1'b0;
        awaddr    = wr_addr;
        wdata     = wr_data;
        wstrb     = '1;
        araddr    = rd_addr;
        awvalid   = 1'b1;
        wvalid    = 1'b1;
        arvalid   = 1'b1;
        // All three address and data channels in the same cycle
        while (!(aw_done && w_done && ar_done)) begin
            @(negedge clk);
            aw_done = aw_done || (awvalid && awready);
            w_done  = w_done || (wvalid && wready);
            ar_done = ar_done || (arvalid && arready);
            @(posedge clk);
            #1;
            awvalid = awvalid && !aw_done;
            wvalid  = wvalid && !w_done;
            arvalid = arvalid && !ar_done;
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_failure("request channels not accepted within timeout");
            end
        end
        waited = 0;
        @(negedge clk);
        while (!(bvalid && rvalid)) begin
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_failure("B and R responses not both valid within timeout");
            end
            @(negedge clk);
        end
        // Responses must stay put while nobody takes them
        for (int i = 0; i < 10; i++) begin
            if (!(bvalid && rvalid)) begin
                stop_on_failure("a response dropped while ready was low");
            end
            check_resp(RESP_OKAY, bresp);
            check_resp(RESP_OKAY, rresp);
            check_data(ref_mem[30], rdata);
            // No new request taken before its response completes
            expect_flag("awready", 1'b0, awready);
            expect_flag("wready", 1'b0, wready);
            expect_flag("arready", 1'b0, arready);
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        bready = 1'b1;
        rready = 1'b1;
        @(posedge clk);
        #1;
        bready = 1'b0;
        rready = 1'b0;
        ref_mem[12] = merge_bytes(ref_mem[12], wr_data, '1);
        read_and_check(wr_addr);
        read_and_check(rd_addr);
    endtask

    task automatic random_traffic();
        int    word;
        int    order;
        addr_t addr;
        data_t data;
        strb_t strb;
        test_name = "random_traffic";
        for (int n = 0; n < 200; n++) begin
            // A few words past the end for error responses
            word  = {$random(seed)} % (`MEM_WORDS + 8);
            addr  = addr_t'(word * 4 + ({$random(seed)} % 4));
            data  = data_t'($random(seed));
            strb  = strb_t'($random(seed));
            order = {$random(seed)} % 3;
            if ({$random(seed)} % 2 == 0) begin
                write_and_check(addr, data, strb, order);
            end else begin
                read_and_check(addr);
            end
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    initial begin
        seed    = 55;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            ref_mem[i] = data_t'(i);
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        reset_contents();
        full_write_readback();
        partial_strobe();
        out_of_range();
        concurrent_backpressure();
        random_traffic();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
